//--- include/board_settings.svh
// ********************************************************************
// Board-support defaults: colour width, button count, input polarity,
// reset stretch, LED blink rate and status word bit positions
// ********************************************************************
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// Game interface
`define BOARD_COLORW        4
`define BOARD_BUTTONS       2
`define BOARD_ACTIVE_LOW    1

// Game reset held this many clocks after the last cause clears
`define BOARD_RST_CYCLES    16

// Frames between LED toggles while the OSD is open
`define BOARD_BLINK_FRAMES  4

// Status word bits
`define ST_BW               5
`define ST_PAUSE            7
`define ST_FM_OFF           8
`define ST_PSG_OFF          9
`define ST_TEST             11
`define ST_FLIP             12
`define ST_FX_LO            13

`endif

//--- rtl/board_pkg.sv
// ********************************************************************
// Board-support types: joysticks, video buses and decoded settings
// ********************************************************************
`default_nettype none

`include "board_settings.svh"

package board_pkg;

    // Game side joystick, one bit per control
    typedef struct packed {
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_t;

    // Raw board joystick, only the low ten bits reach the game
    typedef struct packed {
        logic [5:0] extra;
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } board_joy_t;

    typedef struct packed {
        logic [`BOARD_COLORW-1:0] r;
        logic [`BOARD_COLORW-1:0] g;
        logic [`BOARD_COLORW-1:0] b;
    } rgb_in_t;

    // Blanking is active low
    typedef struct packed {
        rgb_in_t rgb;
        logic    lhbl;
        logic    lvbl;
        logic    hs;
        logic    vs;
    } video_in_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       de;
    } video_out_t;

    typedef struct packed {
        logic       test;
        logic       pause;
        logic       flip;
        logic [1:0] fxlevel;
        logic       bw_en;
        logic       enable_fm;
        logic       enable_psg;
    } dip_cfg_t;

endpackage

`default_nettype wire

//--- rtl/board_reset.sv
// ********************************************************************
// Game reset: PLL lock synchroniser and reset stretch counter
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module board_reset (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic flip,
    output logic game_rst_n
);

    localparam int CNT_W = $clog2(`BOARD_RST_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`BOARD_RST_CYCLES - 1);

    logic [1:0]       lock_sync;
    logic             flip_last;
    logic             hold;
    logic [CNT_W-1:0] cnt;

    // Lock comes from the PLL domain
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lock_sync <= 2'b00;
            flip_last <= 1'b0;
        end else begin
            lock_sync <= {lock_sync[0], pll_locked};
            flip_last <= flip;
        end
    end

    // Any flip change restarts the game
    assign hold = ~lock_sync[1] | downloading | rst_req | (flip ^ flip_last);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            game_rst_n <= 1'b0;
        end else if (hold) begin
            cnt        <= '0;
            game_rst_n <= 1'b0;
        end else if (cnt == CNT_LAST) begin
            game_rst_n <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_inputs.sv
// ********************************************************************
// Player inputs: button mask, cocktail flip, polarity and lock
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module board_inputs #(
    parameter int BUTTONS = `BOARD_BUTTONS
) (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   downloading,
    input  logic                   flip,
    input  board_pkg::board_joy_t  board_joy [4],
    input  logic [3:0]             board_start,
    input  logic [3:0]             board_coin,
    output board_pkg::joy_t        game_joy [4],
    output logic [3:0]             game_start,
    output logic [3:0]             game_coin
);

    import board_pkg::*;

    localparam logic       ACTIVE_LOW = 1'(`BOARD_ACTIVE_LOW);
    // Directions plus the buttons the game uses
    localparam logic [9:0] JOY_MASK = 10'((1 << (4 + BUTTONS)) - 1);
    localparam logic [9:0] JOY_OFF  = {10{ACTIVE_LOW}};
    localparam logic [3:0] BTN_OFF  = {4{ACTIVE_LOW}};

    joy_t joy_next [4];

    always_comb begin
        joy_t masked;
        for (int i = 0; i < 4; i++) begin
            masked      = board_joy[i][9:0] & JOY_MASK;
            joy_next[i] = masked;
            // Cocktail cabinet, players 1 and 2 face each other
            if (flip && i < 2) begin
                joy_next[i].right = masked.left;
                joy_next[i].left  = masked.right;
                joy_next[i].up    = masked.down;
                joy_next[i].down  = masked.up;
            end
            joy_next[i] = joy_next[i] ^ JOY_OFF;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                game_joy[i] <= JOY_OFF;
            end
            game_start <= BTN_OFF;
            game_coin  <= BTN_OFF;
        end else if (downloading) begin
            // Game sees an idle panel during ROM load
            for (int i = 0; i < 4; i++) begin
                game_joy[i] <= JOY_OFF;
            end
            game_start <= BTN_OFF;
            game_coin  <= BTN_OFF;
        end else begin
            for (int i = 0; i < 4; i++) begin
                game_joy[i] <= joy_next[i];
            end
            game_start <= board_start ^ BTN_OFF;
            game_coin  <= board_coin ^ BTN_OFF;
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_dip.sv
// ********************************************************************
// DIP and OSD settings decoded from the status word
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module board_dip (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  logic [63:0]         status,
    output board_pkg::dip_cfg_t cfg
);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else begin
            cfg.test    <= status[`ST_TEST];
            cfg.pause   <= status[`ST_PAUSE];
            cfg.flip    <= status[`ST_FLIP];
            cfg.fxlevel <= status[`ST_FX_LO +: 2];
            cfg.bw_en   <= status[`ST_BW];
            // OSD stores these as disable bits
            cfg.enable_fm  <= ~status[`ST_FM_OFF];
            cfg.enable_psg <= ~status[`ST_PSG_OFF];
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_led.sv
// ********************************************************************
// Status LED source select with frame-counted blink
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module board_led (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       lvbl,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int FRM_W = $clog2(`BOARD_BLINK_FRAMES + 1);
    localparam logic [FRM_W-1:0] FRM_LAST = FRM_W'(`BOARD_BLINK_FRAMES - 1);

    logic             lvbl_last;
    logic             frame_end;
    logic [FRM_W-1:0] frames;
    logic             blink;

    // Start of vertical blank
    assign frame_end = lvbl_last & ~lvbl;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_last <= 1'b0;
            frames    <= '0;
            blink     <= 1'b0;
        end else begin
            lvbl_last <= lvbl;
            if (!osd_shown) begin
                frames <= '0;
                blink  <= 1'b0;
            end else if (frame_end) begin
                if (frames == FRM_LAST) begin
                    frames <= '0;
                    blink  <= ~blink;
                end else begin
                    frames <= frames + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            led <= 1'b0;
        end else begin
            led <= downloading ? 1'b1 : (osd_shown ? blink : game_led[0]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_video.sv
// ********************************************************************
// Base video: horizontal bandwidth filter, 8-bit colour, data enable
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module board_video #(
    parameter int COLORW = `BOARD_COLORW
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  bw_en,
    input  board_pkg::video_in_t  vin,
    output board_pkg::video_out_t vout
);

    import board_pkg::*;

    // One extra bit holds the filter sum
    localparam int W = COLORW + 1;

    rgb_in_t prev;
    logic    de;

    // Sum of neighbours, or the plain colour padded with its MSB
    function automatic logic [W-1:0] filt(
        input logic [COLORW-1:0] cur,
        input logic [COLORW-1:0] prv,
        input logic              en
    );
        if (en) begin
            return W'(cur) + W'(prv);
        end
        return {cur, cur[COLORW-1]};
    endfunction

    // Repeat the top bits to fill the low end
    function automatic logic [7:0] extend8(input logic [W-1:0] v);
        logic [7:0] res;
        for (int i = 0; i < 8; i++) begin
            res[7-i] = v[W-1-(i % W)];
        end
        return res;
    endfunction

    assign de = vin.lhbl & vin.lvbl;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            prev <= '0;
            vout <= '0;
        end else if (pxl_cen) begin
            prev    <= vin.rgb;
            vout.r  <= de ? extend8(filt(vin.rgb.r, prev.r, bw_en)) : 8'd0;
            vout.g  <= de ? extend8(filt(vin.rgb.g, prev.g, bw_en)) : 8'd0;
            vout.b  <= de ? extend8(filt(vin.rgb.b, prev.b, bw_en)) : 8'd0;
            vout.hs <= vin.hs;
            vout.vs <= vin.vs;
            vout.de <= de;
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_top.sv
// ********************************************************************
// Board-support top: reset, inputs, settings, LED and video blocks
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module board_top (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic                  pll_locked,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  logic                  osd_shown,
    input  logic                  pxl_cen,
    input  logic [1:0]            game_led,
    input  logic [63:0]           status,
    input  board_pkg::board_joy_t board_joy [4],
    input  logic [3:0]            board_start,
    input  logic [3:0]            board_coin,
    input  board_pkg::video_in_t  vin,
    output logic                  game_rst_n,
    output logic                  led,
    output board_pkg::joy_t       game_joy [4],
    output logic [3:0]            game_start,
    output logic [3:0]            game_coin,
    output board_pkg::dip_cfg_t   cfg,
    output board_pkg::video_out_t vout
);

    board_dip u_dip (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .status      ( status      ),
        .cfg         ( cfg         )
    );

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .flip        ( cfg.flip    ),
        .game_rst_n  ( game_rst_n  )
    );

    board_inputs #(
        .BUTTONS     ( `BOARD_BUTTONS )
    ) u_inputs (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .flip        ( cfg.flip    ),
        .board_joy   ( board_joy   ),
        .board_start ( board_start ),
        .board_coin  ( board_coin  ),
        .game_joy    ( game_joy    ),
        .game_start  ( game_start  ),
        .game_coin   ( game_coin   )
    );

    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .lvbl        ( vin.lvbl    ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

    board_video #(
        .COLORW      ( `BOARD_COLORW )
    ) u_video (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pxl_cen     ( pxl_cen     ),
        .bw_en       ( cfg.bw_en   ),
        .vin         ( vin         ),
        .vout        ( vout        )
    );

endmodule

`default_nettype wire

//--- dv/tb_board.sv
// ********************************************************************
// Board-support testbench: reset, DIP, inputs, video and LED tests
// ********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module tb_board;

    import board_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk_sys;
    logic        rst_n;
    logic        pll_locked;
    logic        rst_req;
    logic        downloading;
    logic        osd_shown;
    logic        pxl_cen;
    logic [1:0]  game_led;
    logic [63:0] status;
    board_joy_t  board_joy [4];
    logic [3:0]  board_start;
    logic [3:0]  board_coin;
    video_in_t   vin;
    logic        game_rst_n;
    logic        led;
    joy_t        game_joy [4];
    logic [3:0]  game_start;
    logic [3:0]  game_coin;
    dip_cfg_t    cfg;
    video_out_t  vout;

    logic [31:0] seed = 32'd37637;
    int          cycles = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    board_top u_board_top (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .pxl_cen     ( pxl_cen     ),
        .game_led    ( game_led    ),
        .status      ( status      ),
        .board_joy   ( board_joy   ),
        .board_start ( board_start ),
        .board_coin  ( board_coin  ),
        .vin         ( vin         ),
        .game_rst_n  ( game_rst_n  ),
        .led         ( led         ),
        .game_joy    ( game_joy    ),
        .game_start  ( game_start  ),
        .game_coin   ( game_coin   ),
        .cfg         ( cfg         ),
        .vout        ( vout        )
    );

    always #5 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic tally(input logic ok);
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    task automatic check_joy(input string name, input joy_t exp, input joy_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
        tally(exp === act);
    endtask

    task automatic check_cfg(input string name, input dip_cfg_t exp, input dip_cfg_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
        tally(exp === act);
    endtask

    task automatic check_vout(input string name, input video_out_t exp,
                              input video_out_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
        tally(exp === act);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
        tally(exp === act);
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
        tally(exp == act);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("%-16s done, %0d failures", name, n_fail - fails_before);
    endtask

    // Mask, cocktail swap on players 1 and 2, then polarity
    function automatic joy_t expect_joy(input board_joy_t raw, input int idx, input logic flip);
        joy_t j;
        j.buttons = raw.buttons & 6'((1 << `BOARD_BUTTONS) - 1);
        j.up      = (flip && idx < 2) ? raw.down  : raw.up;
        j.down    = (flip && idx < 2) ? raw.up    : raw.down;
        j.left    = (flip && idx < 2) ? raw.right : raw.left;
        j.right   = (flip && idx < 2) ? raw.left  : raw.right;
        return `BOARD_ACTIVE_LOW ? ~j : j;
    endfunction

    // 5-bit filtered value widened by its top three bits
    function automatic logic [7:0] expect_colour(input logic [3:0] cur, input logic [3:0] prv,
                                                 input logic bw);
        logic [4:0] v;
        v = bw ? ({1'b0, cur} + {1'b0, prv}) : {cur, cur[3]};
        return {v, v[4:2]};
    endfunction

    task automatic test_reset();
        int f0;
        int n;
        f0 = n_fail;
        @(posedge clk_sys);
        downloading <= 1'b1;
        repeat (4) @(posedge clk_sys);
        downloading <= 1'b0;
        n = 0;
        // Count edges after the one that clears the download
        @(negedge clk_sys);
        while (game_rst_n !== 1'b1 && n < 100) begin
            @(negedge clk_sys);
            n++;
        end
        check_count("reset stretch", `BOARD_RST_CYCLES, n);
        @(posedge clk_sys);
        status[`ST_FLIP] <= ~status[`ST_FLIP];
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("reset on flip", 1'b0, game_rst_n);
        report_test("reset_stretch", f0);
    endtask

    task automatic test_dip();
        int          f0;
        logic [63:0] sw;
        dip_cfg_t    exp;
        f0 = n_fail;
        for (int n = 0; n < 20; n++) begin
            @(posedge clk_sys);
            sw = {lcg(), lcg()};
            status <= sw;
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            exp.test       = sw[`ST_TEST];
            exp.pause      = sw[`ST_PAUSE];
            exp.flip       = sw[`ST_FLIP];
            exp.fxlevel    = sw[`ST_FX_LO +: 2];
            exp.bw_en      = sw[`ST_BW];
            exp.enable_fm  = ~sw[`ST_FM_OFF];
            exp.enable_psg = ~sw[`ST_PSG_OFF];
            check_cfg("dip decode", exp, cfg);
        end
        report_test("dip_decode", f0);
    endtask

    task automatic test_inputs();
        int          f0;
        logic [31:0] r;
        board_joy_t  raw [4];
        logic [3:0]  st;
        logic [3:0]  cn;
        f0 = n_fail;
        for (int fl = 0; fl < 2; fl++) begin
            @(posedge clk_sys);
            status <= '0;
            status[`ST_FLIP] <= fl[0];
            for (int n = 0; n < 6; n++) begin
                @(posedge clk_sys);
                for (int i = 0; i < 4; i++) begin
                    r = lcg();
                    raw[i] = r[15:0];
                    board_joy[i] <= raw[i];
                end
                st = r[19:16];
                cn = r[23:20];
                board_start <= st;
                board_coin  <= cn;
                repeat (2) @(posedge clk_sys);
                @(negedge clk_sys);
                for (int i = 0; i < 4; i++) begin
                    check_joy("inputs joy", expect_joy(raw[i], i, fl[0]), game_joy[i]);
                end
                for (int b = 0; b < 4; b++) begin
                    check_bit("inputs start", st[b] ^ 1'(`BOARD_ACTIVE_LOW), game_start[b]);
                    check_bit("inputs coin", cn[b] ^ 1'(`BOARD_ACTIVE_LOW), game_coin[b]);
                end
            end
        end
        @(posedge clk_sys);
        downloading <= 1'b1;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        for (int i = 0; i < 4; i++) begin
            check_joy("inputs locked", {10{1'(`BOARD_ACTIVE_LOW)}}, game_joy[i]);
        end
        for (int b = 0; b < 4; b++) begin
            check_bit("inputs locked start", 1'(`BOARD_ACTIVE_LOW), game_start[b]);
            check_bit("inputs locked coin", 1'(`BOARD_ACTIVE_LOW), game_coin[b]);
        end
        @(posedge clk_sys);
        downloading <= 1'b0;
        report_test("input_cond", f0);
    endtask

    task automatic test_video();
        int          f0;
        logic [31:0] r;
        video_in_t   px;
        video_out_t  exp;
        rgb_in_t     prv;
        logic        de;
        f0  = n_fail;
        // No pixel enable has reached the DUT before this test
        prv = '0;
        for (int bw = 0; bw < 2; bw++) begin
            @(posedge clk_sys);
            status <= '0;
            status[`ST_BW] <= bw[0];
            repeat (2) @(posedge clk_sys);
            for (int n = 0; n < 10; n++) begin
                @(posedge clk_sys);
                r       = lcg();
                px.rgb  = r[11:0];
                px.lhbl = (n != 6);
                px.lvbl = (n != 8);
                px.hs   = r[12];
                px.vs   = r[13];
                vin     <= px;
                pxl_cen <= 1'b1;
                @(posedge clk_sys);
                pxl_cen <= 1'b0;
                de      = px.lhbl & px.lvbl;
                exp.r   = de ? expect_colour(px.rgb.r, prv.r, bw[0]) : 8'd0;
                exp.g   = de ? expect_colour(px.rgb.g, prv.g, bw[0]) : 8'd0;
                exp.b   = de ? expect_colour(px.rgb.b, prv.b, bw[0]) : 8'd0;
                exp.hs  = px.hs;
                exp.vs  = px.vs;
                exp.de  = de;
                prv     = px.rgb;
                @(negedge clk_sys);
                check_vout("video path", exp, vout);
            end
        end
        report_test("video_path", f0);
    endtask

    task automatic pulse_lvbl();
        @(posedge clk_sys);
        vin.lvbl <= 1'b0;
        repeat (3) @(posedge clk_sys);
        vin.lvbl <= 1'b1;
        @(posedge clk_sys);
    endtask

    task automatic test_led();
        int          f0;
        logic [31:0] r;
        f0 = n_fail;
        @(posedge clk_sys);
        downloading <= 1'b1;
        vin.lvbl    <= 1'b1;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit("led download", 1'b1, led);
        @(posedge clk_sys);
        downloading <= 1'b0;
        osd_shown   <= 1'b1;
        for (int k = 1; k <= `BOARD_BLINK_FRAMES; k++) begin
            pulse_lvbl();
            @(negedge clk_sys);
            check_bit("led blink", k == `BOARD_BLINK_FRAMES, led);
        end
        @(posedge clk_sys);
        osd_shown <= 1'b0;
        for (int n = 0; n < 4; n++) begin
            @(posedge clk_sys);
            r = lcg();
            game_led <= r[1:0];
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            check_bit("led game", r[0], led);
        end
        report_test("led", f0);
    endtask

    initial begin
        clk_sys     = 1'b0;
        rst_n       = 1'b0;
        pll_locked  = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        osd_shown   = 1'b0;
        pxl_cen     = 1'b0;
        game_led    = 2'b00;
        status      = '0;
        board_start = 4'h0;
        board_coin  = 4'h0;
        vin         = '0;
        for (int i = 0; i < 4; i++) begin
            board_joy[i] = '0;
        end
        repeat (2) @(posedge clk_sys);
        rst_n <= 1'b1;
        test_reset();
        test_dip();
        test_inputs();
        test_video();
        test_led();
        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
rtl/board_pkg.sv
rtl/board_reset.sv
rtl/board_inputs.sv
rtl/board_dip.sv
rtl/board_led.sv
rtl/board_video.sv
rtl/board_top.sv
dv/tb_board.sv

//--- Makefile
# Verilator build and run for the board-support core

VERILATOR  ?= verilator
TOP        ?= tb_board
DUT_TOP    ?= board_top
FLIST      ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= -Wno-fatal
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR)
